//--- run.sh
#!/bin/sh
# Builds the execute stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module execute_unit_tb -f sources.f -o execute_unit_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/execute_unit_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "^TEST RESULT: PASS$"; then
  exit 0
fi
echo "Pass line not found in simulation output"
exit 1

//--- source/alu.sv
`timescale 1ns/1ps

module alu (
  input  execute_pkg::alu_op_t opcode,
  input  execute_pkg::word_t   operand1,
  input  execute_pkg::word_t   operand2,
  output execute_pkg::word_t   result
);
  import execute_pkg::*;

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;
  logic       equal;

  assign shamt       = operand2[4:0];
  assign lt_signed   = $signed(operand1) < $signed(operand2);
  assign lt_unsigned = operand1 < operand2;
  assign equal       = operand1 == operand2;

  always_comb begin
    case (opcode)
      ALU_ADD:   result = operand1 + operand2;
      ALU_SUB:   result = operand1 - operand2;
      ALU_SLL:   result = operand1 << shamt;
      ALU_SLT:   result = {31'd0, lt_signed};
      ALU_SLTU:  result = {31'd0, lt_unsigned};
      ALU_XOR:   result = operand1 ^ operand2;
      ALU_SRL:   result = operand1 >> shamt;
      ALU_SRA:   result = word_t'($signed(operand1) >>> shamt);
      ALU_OR:    result = operand1 | operand2;
      ALU_AND:   result = operand1 & operand2;
      // Used for lui and CSR writes
      ALU_PASS2: result = operand2;
      // Only bit 0 of a branch compare matters to the redirect logic
      ALU_EQ:    result = {31'd0, equal};
      ALU_NE:    result = {31'd0, !equal};
      ALU_LT:    result = {31'd0, lt_signed};
      ALU_GE:    result = {31'd0, !lt_signed};
      ALU_LTU:   result = {31'd0, lt_unsigned};
      ALU_GEU:   result = {31'd0, !lt_unsigned};
      default:   result = '0;
    endcase
  end

endmodule

//--- source/execute_pkg.sv
package execute_pkg;

  typedef logic [31:0] word_t;
  typedef logic [7:0]  alu_op_t;
  typedef logic [2:0]  npc_sel_t;
  typedef logic [1:0]  wdata_sel_t;
  typedef logic [1:0]  csr_src_sel_t;
  typedef logic [1:0]  op1_sel_t;
  typedef logic [3:0]  op2_sel_t;

  // Any ALU opcode not listed here yields zero
  localparam alu_op_t ALU_ADD   = 8'h00;
  localparam alu_op_t ALU_SUB   = 8'h01;
  localparam alu_op_t ALU_SLL   = 8'h02;
  localparam alu_op_t ALU_SLT   = 8'h03;
  localparam alu_op_t ALU_SLTU  = 8'h04;
  localparam alu_op_t ALU_XOR   = 8'h05;
  localparam alu_op_t ALU_SRL   = 8'h06;
  localparam alu_op_t ALU_SRA   = 8'h07;
  localparam alu_op_t ALU_OR    = 8'h08;
  localparam alu_op_t ALU_AND   = 8'h09;
  localparam alu_op_t ALU_PASS2 = 8'h0a;
  // Compares used for branch decisions
  localparam alu_op_t ALU_EQ    = 8'h10;
  localparam alu_op_t ALU_NE    = 8'h11;
  localparam alu_op_t ALU_LT    = 8'h14;
  localparam alu_op_t ALU_GE    = 8'h15;
  localparam alu_op_t ALU_LTU   = 8'h16;
  localparam alu_op_t ALU_GEU   = 8'h17;

  localparam npc_sel_t NPC_SEQ    = 3'd0;
  localparam npc_sel_t NPC_JAL    = 3'd1;
  localparam npc_sel_t NPC_JALR   = 3'd2;
  localparam npc_sel_t NPC_BRANCH = 3'd3;
  localparam npc_sel_t NPC_TRAP   = 3'd4;

  localparam wdata_sel_t WB_ALU    = 2'd0;
  localparam wdata_sel_t WB_LINK   = 2'd1;
  localparam wdata_sel_t WB_TARGET = 2'd2;
  localparam wdata_sel_t WB_CSR    = 2'd3;

  // Machine-mode environment call cause code
  localparam word_t ECALL_CAUSE = 32'd11;

endpackage

//--- source/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      block,
  input  logic                      decode_valid,
  input  logic                      fence_i,
  input  execute_pkg::word_t        pc,
  input  execute_pkg::word_t        imm,
  input  execute_pkg::word_t        src1,
  input  execute_pkg::word_t        src2,
  input  execute_pkg::word_t        csr_src,
  input  execute_pkg::word_t        forward_data,
  input  execute_pkg::npc_sel_t     npc_sel,
  input  execute_pkg::wdata_sel_t   exu_r_wdata_sel,
  input  execute_pkg::csr_src_sel_t csr_src_sel,
  input  logic                      csr_wdata1_sel,
  input  execute_pkg::alu_op_t      alu_opcode,
  input  execute_pkg::op1_sel_t     alu_operand1_sel,
  input  execute_pkg::op2_sel_t     alu_operand2_sel,
  output execute_pkg::word_t        alu_result,
  output execute_pkg::word_t        wsrc,
  output execute_pkg::word_t        npc,
  output execute_pkg::word_t        snpc,
  output execute_pkg::word_t        exu_r_wdata,
  output execute_pkg::word_t        csr_wdata1,
  output execute_pkg::word_t        csr_wdata2,
  output logic                      npc_valid,
  output logic                      clear_pipeline,
  output logic                      clear_cache
);
  import execute_pkg::*;

  alu_op_t opcode;
  word_t   operand1;
  word_t   operand2;
  word_t   dnpc;
  word_t   csr_src_q;

  operand_stage i_operand_stage (
    .clock(clock), .reset(reset), .block(block),
    .pc(pc), .imm(imm), .src1(src1), .src2(src2),
    .csr_src(csr_src), .forward_data(forward_data),
    .alu_result(alu_result), .exu_r_wdata(exu_r_wdata), .csr_wdata1(csr_wdata1),
    .alu_opcode(alu_opcode), .alu_operand1_sel(alu_operand1_sel),
    .alu_operand2_sel(alu_operand2_sel), .csr_src_sel(csr_src_sel),
    .opcode(opcode), .operand1(operand1), .operand2(operand2),
    .snpc(snpc), .dnpc(dnpc), .wsrc(wsrc), .csr_src_q(csr_src_q)
  );

  alu i_alu (
    .opcode(opcode), .operand1(operand1), .operand2(operand2), .result(alu_result)
  );

  redirect_unit i_redirect_unit (
    .clock(clock), .reset(reset), .block(block),
    .decode_valid(decode_valid), .fence_i(fence_i), .csr_wdata1_sel(csr_wdata1_sel),
    .npc_sel(npc_sel), .exu_r_wdata_sel(exu_r_wdata_sel),
    .pc(pc), .snpc(snpc), .dnpc(dnpc), .alu_result(alu_result), .csr_src_q(csr_src_q),
    .npc(npc), .exu_r_wdata(exu_r_wdata), .csr_wdata1(csr_wdata1), .csr_wdata2(csr_wdata2),
    .npc_valid(npc_valid), .clear_pipeline(clear_pipeline), .clear_cache(clear_cache)
  );

endmodule

//--- source/operand_stage.sv
`timescale 1ns/1ps

module operand_stage (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      block,
  input  execute_pkg::word_t        pc,
  input  execute_pkg::word_t        imm,
  input  execute_pkg::word_t        src1,
  input  execute_pkg::word_t        src2,
  input  execute_pkg::word_t        csr_src,
  input  execute_pkg::word_t        forward_data,
  input  execute_pkg::word_t        alu_result,
  input  execute_pkg::word_t        exu_r_wdata,
  input  execute_pkg::word_t        csr_wdata1,
  input  execute_pkg::alu_op_t      alu_opcode,
  input  execute_pkg::op1_sel_t     alu_operand1_sel,
  input  execute_pkg::op2_sel_t     alu_operand2_sel,
  input  execute_pkg::csr_src_sel_t csr_src_sel,
  output execute_pkg::alu_op_t      opcode,
  output execute_pkg::word_t        operand1,
  output execute_pkg::word_t        operand2,
  output execute_pkg::word_t        snpc,
  output execute_pkg::word_t        dnpc,
  output execute_pkg::word_t        wsrc,
  output execute_pkg::word_t        csr_src_q
);
  import execute_pkg::*;

  word_t csr_choice;
  word_t store_choice;
  word_t operand1_next;
  word_t operand2_next;

  // Lower selector bits win; feedback comes from the instruction still in this stage
  always_comb begin
    csr_choice = csr_src_sel[0] ? alu_result :
                 csr_src_sel[1] ? csr_wdata1 : csr_src;

    store_choice = alu_operand2_sel[2] ? exu_r_wdata :
                   alu_operand2_sel[3] ? forward_data : src2;

    operand1_next = alu_operand1_sel[0] ? exu_r_wdata :
                    alu_operand1_sel[1] ? forward_data : src1;

    // Store data shares the tail of the operand 2 chain
    operand2_next = alu_operand2_sel[0] ? imm :
                    alu_operand2_sel[1] ? csr_choice : store_choice;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      opcode    <= '0;
      operand1  <= '0;
      operand2  <= '0;
      snpc      <= '0;
      dnpc      <= '0;
      wsrc      <= '0;
      csr_src_q <= '0;
    end else if (!block) begin
      opcode    <= alu_opcode;
      operand1  <= operand1_next;
      operand2  <= operand2_next;
      snpc      <= pc + 32'd4;
      dnpc      <= pc + imm;
      wsrc      <= store_choice;
      csr_src_q <= csr_choice;
    end
  end

  // A stall freezes the whole stage for the next cycle
  property hold_on_block;
    @(posedge clock) disable iff (reset)
      block |=> ($stable(opcode) && $stable(operand1) && $stable(operand2) &&
                 $stable(snpc) && $stable(dnpc) && $stable(wsrc) && $stable(csr_src_q));
  endproperty

  assert property (hold_on_block)
    else $error("operand stage changed while blocked");

endmodule

//--- source/redirect_unit.sv
`timescale 1ns/1ps

module redirect_unit (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    block,
  input  logic                    decode_valid,
  input  logic                    fence_i,
  input  logic                    csr_wdata1_sel,
  input  execute_pkg::npc_sel_t   npc_sel,
  input  execute_pkg::wdata_sel_t exu_r_wdata_sel,
  input  execute_pkg::word_t      pc,
  input  execute_pkg::word_t      snpc,
  input  execute_pkg::word_t      dnpc,
  input  execute_pkg::word_t      alu_result,
  input  execute_pkg::word_t      csr_src_q,
  output execute_pkg::word_t      npc,
  output execute_pkg::word_t      exu_r_wdata,
  output execute_pkg::word_t      csr_wdata1,
  output execute_pkg::word_t      csr_wdata2,
  output logic                    npc_valid,
  output logic                    clear_pipeline,
  output logic                    clear_cache
);
  import execute_pkg::*;

  npc_sel_t   npc_sel_q;
  wdata_sel_t wdata_sel_q;
  logic       csr_wdata1_sel_q;
  word_t      pc_q;

  always_comb begin
    case (npc_sel_q)
      NPC_SEQ:    npc = snpc;
      NPC_JAL:    npc = dnpc;
      NPC_JALR:   npc = {alu_result[31:1], 1'b0};
      NPC_BRANCH: npc = alu_result[0] ? dnpc : snpc;
      NPC_TRAP:   npc = csr_src_q;
      default:    npc = '0;
    endcase
  end

  always_comb begin
    case (wdata_sel_q)
      WB_ALU:    exu_r_wdata = alu_result;
      WB_LINK:   exu_r_wdata = snpc;
      WB_TARGET: exu_r_wdata = dnpc;
      WB_CSR:    exu_r_wdata = csr_src_q;
    endcase
  end

  // Any redirect or fence.i flushes younger instructions
  assign clear_pipeline = (npc_valid && npc_sel_q != NPC_SEQ) || clear_cache;

  always_ff @(posedge clock) begin
    if (reset) begin
      npc_valid        <= 1'b0;
      clear_cache      <= 1'b0;
      npc_sel_q        <= NPC_SEQ;
      wdata_sel_q      <= WB_ALU;
      csr_wdata1_sel_q <= 1'b0;
      csr_wdata1       <= '0;
      pc_q             <= '0;
      csr_wdata2       <= '0;
    end else if (!block) begin
      npc_valid        <= decode_valid && !clear_pipeline;
      clear_cache      <= fence_i;
      npc_sel_q        <= npc_sel;
      wdata_sel_q      <= exu_r_wdata_sel;
      csr_wdata1_sel_q <= csr_wdata1_sel;
      csr_wdata1       <= csr_wdata1_sel_q ? ECALL_CAUSE : alu_result;
      pc_q             <= pc;
      csr_wdata2       <= pc_q;
    end
  end

  assert property (@(posedge clock) disable iff (reset)
                   (fence_i && !block) |=> clear_pipeline)
    else $error("fence.i did not flush the pipeline");

  assert property (@(posedge clock) disable iff (reset)
                   (npc_valid && npc_sel_q == NPC_JALR) |-> !npc[0])
    else $error("jalr target has bit 0 set");

endmodule

//--- sources.f
+incdir+tests
source/execute_pkg.sv
source/alu.sv
source/operand_stage.sv
source/redirect_unit.sv
source/execute_unit.sv
tests/execute_unit_tb.sv

//--- tests/execute_model.svh
`ifndef EXECUTE_MODEL_SVH
`define EXECUTE_MODEL_SVH

logic [31:0] lfsr_state = 32'h57cb_238c;

// Registers of the stage as the model sees them
alu_op_t    m_opcode;
word_t      m_operand1, m_operand2, m_snpc, m_dnpc, m_wsrc, m_csr_src_q;
word_t      m_csr_wdata1, m_csr_wdata2, m_pc_q;
npc_sel_t   m_npc_sel;
wdata_sel_t m_wdata_sel;
logic       m_csr_wdata1_sel, m_npc_valid, m_clear_cache;

// Values that settle combinationally from the registers above
word_t      m_alu, m_npc, m_wdata;
logic       m_clear_pipeline;

// Galois LFSR stepped once per bit handed out
function automatic word_t random_bits(input int count);
  word_t value;
  value = '0;
  for (int i = 0; i < count; i++) begin
    value = {value[30:0], lfsr_state[0]};
    lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
  end
  return value;
endfunction

function automatic word_t alu_model(input alu_op_t op, input word_t a, input word_t b);
  logic [32:0] diff;
  logic        below;
  logic        less;
  logic [4:0]  sh;
  diff  = {1'b0, a} - {1'b0, b};
  below = diff[32];
  // Differing signs decide a signed compare on their own
  less  = (a[31] != b[31]) ? a[31] : below;
  sh    = b[4:0];
  case (op)
    ALU_ADD:           return a + b;
    ALU_SUB:           return diff[31:0];
    ALU_SLL:           return a << sh;
    ALU_SLT, ALU_LT:   return {31'd0, less};
    ALU_SLTU, ALU_LTU: return {31'd0, below};
    ALU_XOR:           return a ^ b;
    ALU_SRL:           return a >> sh;
    ALU_SRA:           return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'd0);
    ALU_OR:            return a | b;
    ALU_AND:           return a & b;
    ALU_PASS2:         return b;
    ALU_EQ:            return {31'd0, a == b};
    ALU_NE:            return {31'd0, a != b};
    ALU_GE:            return {31'd0, !less};
    ALU_GEU:           return {31'd0, !below};
    default:           return '0;
  endcase
endfunction

task automatic settle_model;
  m_alu = alu_model(m_opcode, m_operand1, m_operand2);
  case (m_npc_sel)
    NPC_SEQ:    m_npc = m_snpc;
    NPC_JAL:    m_npc = m_dnpc;
    NPC_JALR:   m_npc = m_alu & 32'hffff_fffe;
    NPC_BRANCH: m_npc = m_alu[0] ? m_dnpc : m_snpc;
    NPC_TRAP:   m_npc = m_csr_src_q;
    default:    m_npc = '0;
  endcase
  case (m_wdata_sel)
    WB_ALU:    m_wdata = m_alu;
    WB_LINK:   m_wdata = m_snpc;
    WB_TARGET: m_wdata = m_dnpc;
    WB_CSR:    m_wdata = m_csr_src_q;
  endcase
  m_clear_pipeline = (m_npc_valid && m_npc_sel != NPC_SEQ) || m_clear_cache;
endtask

task automatic reset_model;
  m_opcode = '0;
  m_operand1 = '0;
  m_operand2 = '0;
  m_snpc = '0;
  m_dnpc = '0;
  m_wsrc = '0;
  m_csr_src_q = '0;
  m_csr_wdata1 = '0;
  m_csr_wdata2 = '0;
  m_pc_q = '0;
  m_npc_sel = NPC_SEQ;
  m_wdata_sel = WB_ALU;
  m_csr_wdata1_sel = 1'b0;
  m_npc_valid = 1'b0;
  m_clear_cache = 1'b0;
  settle_model;
endtask

// One clock edge with the instruction that was on the inputs before it
task automatic step_model;
  word_t csr_choice;
  word_t store_choice;
  word_t first;
  word_t second;
  if (!stim_block) begin
    csr_choice = stim_csr_src_sel[0] ? m_alu :
                 stim_csr_src_sel[1] ? m_csr_wdata1 : stim_csr_src;
    store_choice = stim_operand2_sel[2] ? m_wdata :
                   stim_operand2_sel[3] ? stim_forward_data : stim_src2;
    first = stim_operand1_sel[0] ? m_wdata :
            stim_operand1_sel[1] ? stim_forward_data : stim_src1;
    second = stim_operand2_sel[0] ? stim_imm :
             stim_operand2_sel[1] ? csr_choice : store_choice;
    m_npc_valid = stim_decode_valid && !m_clear_pipeline;
    m_clear_cache = stim_fence_i;
    m_csr_wdata1 = m_csr_wdata1_sel ? ECALL_CAUSE : m_alu;
    m_csr_wdata1_sel = stim_csr_wdata1_sel;
    m_csr_wdata2 = m_pc_q;
    m_pc_q = stim_pc;
    m_npc_sel = stim_npc_sel;
    m_wdata_sel = stim_wdata_sel;
    m_opcode = stim_opcode;
    m_operand1 = first;
    m_operand2 = second;
    m_snpc = stim_pc + 32'd4;
    m_dnpc = stim_pc + stim_imm;
    m_wsrc = store_choice;
    m_csr_src_q = csr_choice;
  end
  settle_model;
endtask

`endif

//--- tests/execute_unit_tb.sv
`timescale 1ns/1ps

module execute_unit_tb;
  import execute_pkg::*;

  localparam int CLOCK_PERIOD = 4;
  localparam int RESET_CYCLES = 4;
  localparam int RUN_LENGTH   = 3000;
  localparam int TIMEOUT_NS   = RUN_LENGTH * CLOCK_PERIOD * 2 + RESET_CYCLES * CLOCK_PERIOD;

  logic         clock;
  logic         reset;
  logic         block;
  logic         decode_valid;
  logic         fence_i;
  word_t        pc;
  word_t        imm;
  word_t        src1;
  word_t        src2;
  word_t        csr_src;
  word_t        forward_data;
  npc_sel_t     npc_sel;
  wdata_sel_t   exu_r_wdata_sel;
  csr_src_sel_t csr_src_sel;
  logic         csr_wdata1_sel;
  alu_op_t      alu_opcode;
  op1_sel_t     alu_operand1_sel;
  op2_sel_t     alu_operand2_sel;

  word_t        alu_result;
  word_t        wsrc;
  word_t        npc;
  word_t        snpc;
  word_t        exu_r_wdata;
  word_t        csr_wdata1;
  word_t        csr_wdata2;
  logic         npc_valid;
  logic         clear_pipeline;
  logic         clear_cache;

  // The instruction currently presented to the DUT
  logic         stim_block, stim_decode_valid, stim_fence_i, stim_csr_wdata1_sel;
  word_t        stim_pc, stim_imm, stim_src1, stim_src2, stim_csr_src, stim_forward_data;
  npc_sel_t     stim_npc_sel;
  wdata_sel_t   stim_wdata_sel;
  csr_src_sel_t stim_csr_src_sel;
  alu_op_t      stim_opcode;
  op1_sel_t     stim_operand1_sel;
  op2_sel_t     stim_operand2_sel;

  int error_count;

  alu_op_t opcode_table [0:16] = '{ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
                                   ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS2, ALU_EQ,
                                   ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU};

  `include "execute_model.svh"

  execute_unit i_execute_unit (.*);

  initial begin
    clock = 1'b0;
    forever #(CLOCK_PERIOD / 2) clock = ~clock;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout after %0d ns, the run never reached its end", TIMEOUT_NS);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  task automatic check_value(input string name, input word_t actual, input word_t expected);
    if (actual !== expected) begin
      $display("ERR time=%0t signal=%s dut=%h expected=%h", $time, name, actual, expected);
      error_count++;
    end
  endtask

  task automatic compare_outputs;
    check_value("alu_result", alu_result, m_alu);
    check_value("wsrc", wsrc, m_wsrc);
    check_value("npc", npc, m_npc);
    check_value("snpc", snpc, m_snpc);
    check_value("exu_r_wdata", exu_r_wdata, m_wdata);
    check_value("csr_wdata1", csr_wdata1, m_csr_wdata1);
    check_value("csr_wdata2", csr_wdata2, m_csr_wdata2);
    check_value("npc_valid", {31'd0, npc_valid}, {31'd0, m_npc_valid});
    check_value("clear_pipeline", {31'd0, clear_pipeline}, {31'd0, m_clear_pipeline});
    check_value("clear_cache", {31'd0, clear_cache}, {31'd0, m_clear_cache});
  endtask

  task automatic apply_stimulus;
    block <= stim_block;
    decode_valid <= stim_decode_valid;
    fence_i <= stim_fence_i;
    pc <= stim_pc;
    imm <= stim_imm;
    src1 <= stim_src1;
    src2 <= stim_src2;
    csr_src <= stim_csr_src;
    forward_data <= stim_forward_data;
    npc_sel <= stim_npc_sel;
    exu_r_wdata_sel <= stim_wdata_sel;
    csr_src_sel <= stim_csr_src_sel;
    csr_wdata1_sel <= stim_csr_wdata1_sel;
    alu_opcode <= stim_opcode;
    alu_operand1_sel <= stim_operand1_sel;
    alu_operand2_sel <= stim_operand2_sel;
  endtask

  task automatic pick_instruction;
    logic [4:0] pick;
    stim_block = random_bits(3) == 0;
    stim_fence_i = random_bits(4) == 0;
    stim_decode_valid = random_bits(2) != 0;
    stim_pc = random_bits(32);
    stim_imm = random_bits(32);
    stim_src1 = random_bits(32);
    // Equal operands now and then so that eq and ge compares go both ways
    stim_src2 = (random_bits(2) == 0) ? stim_src1 : random_bits(32);
    stim_csr_src = random_bits(32);
    stim_forward_data = random_bits(32);
    stim_npc_sel = npc_sel_t'(random_bits(3));
    stim_wdata_sel = wdata_sel_t'(random_bits(2));
    stim_csr_src_sel = csr_src_sel_t'(random_bits(2));
    stim_csr_wdata1_sel = random_bits(1) != 0;
    stim_operand1_sel = op1_sel_t'(random_bits(2));
    stim_operand2_sel = op2_sel_t'(random_bits(4));
    if (random_bits(4) == 0) begin
      stim_opcode = alu_op_t'(random_bits(8));
    end else begin
      pick = 5'(random_bits(5) % 17);
      stim_opcode = opcode_table[pick];
    end
  endtask

  initial begin
    error_count = 0;
    stim_block = 1'b0;
    stim_decode_valid = 1'b0;
    stim_fence_i = 1'b0;
    stim_csr_wdata1_sel = 1'b0;
    stim_pc = '0;
    stim_imm = '0;
    stim_src1 = '0;
    stim_src2 = '0;
    stim_csr_src = '0;
    stim_forward_data = '0;
    stim_npc_sel = '0;
    stim_wdata_sel = '0;
    stim_csr_src_sel = '0;
    stim_opcode = '0;
    stim_operand1_sel = '0;
    stim_operand2_sel = '0;
    reset <= 1'b1;
    apply_stimulus;
    reset_model;

    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;
    pick_instruction;
    apply_stimulus;
    @(negedge clock);
    compare_outputs;

    for (int n = 0; n < RUN_LENGTH; n++) begin
      @(posedge clock);
      step_model;
      pick_instruction;
      apply_stimulus;
      @(negedge clock);
      compare_outputs;
    end

    $display("Checked %0d instructions, %0d errors", RUN_LENGTH, error_count);
    if (error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
